/* hdl/sine_pkg.sv */
/*
 * phase and sample constants, types and the quarter-wave table function
 */

package sine_pkg;

	// ------------------------------------------------------------------
	// phase space
	// ------------------------------------------------------------------
	localparam int PHASE_W     = 10;
	// points per full period
	localparam int PHASE_STEPS = 632;
	// one quadrant of the period
	localparam int QUARTER     = 158;
	localparam int ADDR_W      = 8;

	// ------------------------------------------------------------------
	// sample space
	// ------------------------------------------------------------------
	localparam int SAMPLE_W    = 13;
	// peak value stored in the table
	localparam int AMPLITUDE   = 4095;
	localparam real PI         = 3.14159265358979323846;

	typedef logic [PHASE_W-1:0] phase_t;
	typedef logic [ADDR_W-1:0] rom_addr_t;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// table entry k, sampled at the middle of its phase bin
	function automatic sample_t quarter_value(input int k);
		real angle;
		real value;
		angle = 2.0 * PI * (real'(k) + 0.5) / real'(PHASE_STEPS);
		value = real'(AMPLITUDE) * $sin(angle);
		// entries are all positive, so +0.5 then truncate rounds
		return sample_t'($rtoi(value + 0.5));
	endfunction

endpackage

/* hdl/phase_accumulator.sv */
/*
 * modulo-632 phase accumulator with clear, enable and valid
 */

module phase_accumulator
	import sine_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   enable,
	input  logic   phase_clear,
	input  phase_t phase_step,
	output phase_t phase,
	output logic   phase_valid
);

	// next phase to be issued
	phase_t                 acc;
	// phase issued this cycle, clear wins
	phase_t                 base;
	// one extra bit so the sum never overflows before the wrap
	logic   [PHASE_W:0]     sum;
	phase_t                 wrapped;

	// ------------------------------------------------------------------
	// step and wrap
	// ------------------------------------------------------------------
	assign base = phase_clear ? phase_t'(0) : acc;
	assign sum  = {1'b0, base} + {1'b0, phase_step};

	always_comb begin
		// both terms below PHASE_STEPS, so one subtract is enough
		if (sum >= (PHASE_W+1)'(PHASE_STEPS)) begin
			wrapped = phase_t'(sum - (PHASE_W+1)'(PHASE_STEPS));
		end else begin
			wrapped = phase_t'(sum);
		end
	end

	// ------------------------------------------------------------------
	// registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc         <= '0;
			phase       <= '0;
			phase_valid <= 1'b0;
		end else begin
			phase_valid <= enable;
			if (enable) begin
				// emit current phase, then step past it
				phase <= base;
				acc   <= wrapped;
			end else if (phase_clear) begin
				// idle clear, restart from 0 on next enable
				acc <= '0;
			end
		end
	end

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	// a step at or above the period breaks the single-subtract wrap
	// and lets the phase leave 0 to 631 on the following sample
	a_step_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		enable |-> (phase_step < phase_t'(PHASE_STEPS))
	);

endmodule

/* hdl/quarter_sine_rom.sv */
/*
 * quarter-wave sine table, 158 entries, registered read
 */

module quarter_sine_rom
	import sine_pkg::*;
(
	input  logic      clk,
	input  rom_addr_t rom_addr,
	output sample_t   rom_data
);

	// ------------------------------------------------------------------
	// table storage
	// ------------------------------------------------------------------
	// first quadrant of the period, rising from near 0 to the peak
	sample_t rom [QUARTER];

	// filled once at elaboration, no runtime reload
	initial begin
		for (int k = 0; k < QUARTER; k++) begin
			rom[k] = quarter_value(k);
		end
	end

	// ------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------
	// single registered read, maps onto block memory
	always_ff @(posedge clk) begin
		rom_data <= rom[rom_addr];
	end

endmodule

/* hdl/sine_lookup.sv */
/*
 * quadrant fold, table read and sign restore for one phase per cycle
 * three register stages, flag and valid travel with the data
 */

module sine_lookup
	import sine_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  phase_t    phase,
	input  logic      phase_valid,
	output rom_addr_t rom_addr,
	input  sample_t   rom_data,
	output sample_t   raw_sample,
	output logic      raw_valid
);

	// quadrant boundaries in phase units
	localparam phase_t HALF_START = phase_t'(2 * QUARTER);
	localparam phase_t Q2_START   = phase_t'(QUARTER);
	localparam phase_t Q4_START   = phase_t'(3 * QUARTER);
	localparam phase_t Q2_MIRROR  = phase_t'(2 * QUARTER - 1);
	localparam phase_t Q4_MIRROR  = phase_t'(PHASE_STEPS - 1);

	// folded index before truncation to address width
	phase_t fold;
	logic   negate;

	// stage 1 side signals
	logic   neg_s1;
	logic   valid_s1;
	// stage 2 side signals, aligned with rom_data
	logic   neg_s2;
	logic   valid_s2;

	// ------------------------------------------------------------------
	// stage 1, quadrant decode
	// ------------------------------------------------------------------
	always_comb begin
		if (phase < Q2_START) begin
			// rising first quarter
			fold = phase;
		end else if (phase < HALF_START) begin
			// falling second quarter, mirror about the peak
			fold = Q2_MIRROR - phase;
		end else if (phase < Q4_START) begin
			// third quarter, same shape as the first
			fold = phase - HALF_START;
		end else begin
			// fourth quarter, mirrored like the second
			fold = Q4_MIRROR - phase;
		end
	end

	// second half-period is the negative lobe
	assign negate = (phase >= HALF_START);

	// address register feeds the rom directly
	always_ff @(posedge clk) begin
		rom_addr <= rom_addr_t'(fold);
	end

	// ------------------------------------------------------------------
	// control pipe, stages 1 and 2
	// ------------------------------------------------------------------
	// the rom read is stage 2, so flag and valid wait one more cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			neg_s1    <= 1'b0;
			valid_s1  <= 1'b0;
			neg_s2    <= 1'b0;
			valid_s2  <= 1'b0;
			raw_valid <= 1'b0;
		end else begin
			neg_s1    <= negate;
			valid_s1  <= phase_valid;
			neg_s2    <= neg_s1;
			valid_s2  <= valid_s1;
			raw_valid <= valid_s2;
		end
	end

	// ------------------------------------------------------------------
	// stage 3, sign restore
	// ------------------------------------------------------------------
	// two's complement of the table value on the negative lobe
	always_ff @(posedge clk) begin
		if (neg_s2) begin
			raw_sample <= sample_t'(-rom_data);
		end else begin
			raw_sample <= rom_data;
		end
	end

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	// address handed to the rom must stay inside the table depth
	a_addr_in_table: assert property (
		@(posedge clk) disable iff (!arst_n)
		valid_s1 |-> (rom_addr < rom_addr_t'(QUARTER))
	);

endmodule

/* hdl/amplitude_scaler.sv */
/*
 * signed sample times unsigned gain, arithmetic shift back to sample width
 */

module amplitude_scaler
	import sine_pkg::*;
#(
	parameter int GAIN_W = 9
) (
	input  logic              clk,
	input  logic              arst_n,
	input  sample_t           raw_sample,
	input  logic              raw_valid,
	input  logic [GAIN_W-1:0] gain,
	output sample_t           sample,
	output logic              sample_valid
);

	// gain value that passes the sample unchanged
	localparam int UNITY  = 1 << (GAIN_W - 1);
	// extra bit for the zero-extended gain operand
	localparam int PROD_W = SAMPLE_W + GAIN_W + 1;

	// gain as a positive signed operand
	logic signed [GAIN_W:0]   gain_s;
	logic signed [PROD_W-1:0] product;
	logic signed [PROD_W-1:0] shifted;

	// ------------------------------------------------------------------
	// multiply and shift
	// ------------------------------------------------------------------
	assign gain_s  = $signed({1'b0, gain});
	assign product = raw_sample * gain_s;
	// floor division by unity, negative values round down
	assign shifted = product >>> (GAIN_W - 1);

	// ------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sample       <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= raw_valid;
			// upper bits are sign copies when gain stays at or below unity
			if (raw_valid) begin
				sample <= sample_t'(shifted);
			end
		end
	end

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	// above unity the product no longer fits back into sample_t
	a_gain_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		raw_valid |-> (gain <= GAIN_W'(UNITY))
	);

endmodule

/* hdl/tone_generator.sv */
/*
 * dds tone generator top level
 * accumulator, sine lookup with its table, and gain stage
 */

module tone_generator
	import sine_pkg::*;
#(
	parameter int GAIN_W = 9
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              enable,
	input  logic              phase_clear,
	input  phase_t            phase_step,
	input  logic [GAIN_W-1:0] gain,
	output sample_t           sample,
	output logic              sample_valid
);

	// ------------------------------------------------------------------
	// internal chain
	// ------------------------------------------------------------------
	// accumulator to lookup
	phase_t    phase;
	logic      phase_valid;
	// lookup to table and back
	rom_addr_t rom_addr;
	sample_t   rom_data;
	// lookup to gain stage
	sample_t   raw_sample;
	logic      raw_valid;

	// one cycle, enable to phase_valid
	phase_accumulator u_phase_accumulator (
		.clk         (clk),
		.arst_n      (arst_n),
		.enable      (enable),
		.phase_clear (phase_clear),
		.phase_step  (phase_step),
		.phase       (phase),
		.phase_valid (phase_valid)
	);

	// three cycles, phase_valid to raw_valid
	sine_lookup u_sine_lookup (
		.clk         (clk),
		.arst_n      (arst_n),
		.phase       (phase),
		.phase_valid (phase_valid),
		.rom_addr    (rom_addr),
		.rom_data    (rom_data),
		.raw_sample  (raw_sample),
		.raw_valid   (raw_valid)
	);

	// read register counts as lookup stage 2
	quarter_sine_rom u_quarter_sine_rom (
		.clk      (clk),
		.rom_addr (rom_addr),
		.rom_data (rom_data)
	);

	// one cycle, raw_valid to sample_valid
	amplitude_scaler #(
		.GAIN_W (GAIN_W)
	) u_amplitude_scaler (
		.clk          (clk),
		.arst_n       (arst_n),
		.raw_sample   (raw_sample),
		.raw_valid    (raw_valid),
		.gain         (gain),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

endmodule

/* verification/tone_generator_tb.sv */
/*
 * testbench for the tone generator
 * trace reader, reference model, compare tasks and cycle timeout
 */

module tone_generator_tb
	import sine_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int GAIN_W       = 9;
	// enable driven on one falling edge, sample seen five falling edges later
	localparam int LATENCY      = 5;
	localparam int RESET_CYCLES = 4;
	localparam string TRACE_FILE = "verification/tone_trace.txt";

	logic              clk;
	logic              arst_n;
	logic              enable;
	logic              phase_clear;
	phase_t            phase_step;
	logic [GAIN_W-1:0] gain;
	sample_t           sample;
	logic              sample_valid;

	// test command columns
	string test_name[$];
	int    test_step[$];
	int    test_gain[$];
	int    test_clear_at[$];
	int    test_count[$];
	int    test_gap[$];
	// spot expect columns
	string expect_name[$];
	int    expect_index[$];
	int    expect_value[$];
	bit    expect_used[$];

	// model state
	sample_t              expect_q[$];
	logic [LATENCY-1:0]   enable_hist;
	int                   model_phase;
	int                   cycle_count;
	int                   cycle_limit;
	logic [31:0]          rng_state;
	string                cur_test;

	always #2 clk = ~clk;

	tone_generator #(
		.GAIN_W (GAIN_W)
	) u_tone_generator (
		.clk          (clk),
		.arst_n       (arst_n),
		.enable       (enable),
		.phase_clear  (phase_clear),
		.phase_step   (phase_step),
		.gain         (gain),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	// ------------------------------------------------------------------
	// helpers and reference model
	// ------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// quadrant fold, sign, then gain with floor shift
	function automatic sample_t rule_sample(input int p, input int g);
		int idx;
		int value;
		if (p <= 157) begin
			idx = p;
		end else if (p <= 315) begin
			idx = 315 - p;
		end else if (p <= 473) begin
			idx = p - 316;
		end else begin
			idx = 631 - p;
		end
		value = int'(quarter_value(idx));
		if (p >= 316) begin
			value = -value;
		end
		// int is signed, so >>> rounds toward minus infinity
		value = (value * g) >>> (GAIN_W - 1);
		return sample_t'(value);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s sample_valid expected %b actual %b",
				name, expected, actual));
		end
	endtask

	// ------------------------------------------------------------------
	// one clock cycle: observe outputs, then drive the next inputs
	// ------------------------------------------------------------------
	task automatic drive_cycle(input logic en, input logic clr);
		sample_t exp_value;
		@(negedge clk);
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			abort_run($sformatf("timeout in %s after %0d cycles, outputs stopped",
				cur_test, cycle_count));
		end
		// valid must echo the enable driven LATENCY cycles ago
		check_valid(cur_test, enable_hist[LATENCY-1], sample_valid);
		if (sample_valid === 1'b1) begin
			if (expect_q.size() == 0) begin
				abort_run($sformatf("%s: sample_valid with no sample outstanding", cur_test));
			end
			exp_value = expect_q.pop_front();
			check_sample(cur_test, exp_value, sample);
		end
		enable      = en;
		phase_clear = clr;
		enable_hist = {enable_hist[LATENCY-2:0], en};
	endtask

	// spot values from the trace must match the model
	task automatic check_spot(input int t, input int i, input int p);
		for (int e = 0; e < expect_name.size(); e++) begin
			if (expect_name[e] == test_name[t] && expect_index[e] == i) begin
				check_sample({test_name[t], " trace"}, sample_t'(expect_value[e]),
					rule_sample(p, test_gain[t]));
				expect_used[e] = 1'b1;
			end
		end
	endtask

	task automatic read_trace();
		int    fd;
		int    r;
		string kw;
		string rest;
		string name;
		int    step;
		int    gain_value;
		int    clear_at;
		int    count;
		int    gap;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			abort_run("cannot open the trace file verification/tone_trace.txt");
		end
		while ($fscanf(fd, "%s", kw) == 1) begin
			if (kw.substr(0, 0) == "#") begin
				r = $fgets(rest, fd);
			end else if (kw == "test") begin
				r = $fscanf(fd, "%s %d %d %d %d %d", name, step, gain_value,
					clear_at, count, gap);
				if (r != 6) begin
					abort_run("malformed test line in the trace file");
				end
				test_name.push_back(name);
				test_step.push_back(step);
				test_gain.push_back(gain_value);
				test_clear_at.push_back(clear_at);
				test_count.push_back(count);
				test_gap.push_back(gap);
			end else if (kw == "expect") begin
				r = $fscanf(fd, "%s %d %d", name, count, gain_value);
				if (r != 3) begin
					abort_run("malformed expect line in the trace file");
				end
				expect_name.push_back(name);
				expect_index.push_back(count);
				expect_value.push_back(gain_value);
				expect_used.push_back(1'b0);
			end else begin
				abort_run($sformatf("unknown keyword %s in the trace file", kw));
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------------
	// one trace test
	// ------------------------------------------------------------------
	task automatic run_test(input int t);
		int   p;
		logic gap_taken;
		logic clr;
		cur_test   = test_name[t];
		phase_step = phase_t'(test_step[t]);
		gain       = GAIN_W'(test_gain[t]);
		gap_taken  = 1'b0;
		for (int i = 0; i < test_count[t]; i++) begin
			// at most one idle cycle ahead of each sample
			if (test_gap[t] != 0) begin
				rng_state = xorshift32(rng_state);
				if (!gap_taken && rng_state[1:0] == 2'b00) begin
					drive_cycle(1'b0, 1'b0);
					gap_taken = 1'b1;
				end else begin
					gap_taken = 1'b0;
				end
			end
			clr = (i == test_clear_at[t]);
			p   = clr ? 0 : model_phase;
			check_spot(t, i, p);
			expect_q.push_back(rule_sample(p, test_gain[t]));
			model_phase = (p + test_step[t]) % PHASE_STEPS;
			drive_cycle(1'b1, clr);
		end
		// pipeline depth is fixed, so the last sample lands within LATENCY
		repeat (LATENCY) drive_cycle(1'b0, 1'b0);
		if (expect_q.size() != 0) begin
			abort_run($sformatf("%s ended with %0d samples never delivered",
				cur_test, expect_q.size()));
		end
	endtask

	initial begin
		int total_samples;
		int gap_allowance;
		clk         = 1'b0;
		arst_n      = 1'b0;
		enable      = 1'b0;
		phase_clear = 1'b0;
		phase_step  = '0;
		gain        = '0;
		enable_hist = '0;
		model_phase = 0;
		cycle_count = 0;
		rng_state   = 32'h4263;
		cur_test    = "reset";
		read_trace();
		total_samples = 0;
		gap_allowance = 0;
		for (int t = 0; t < test_name.size(); t++) begin
			total_samples += test_count[t];
			if (test_gap[t] != 0) begin
				gap_allowance += test_count[t];
			end
		end
		cycle_limit = 2 * total_samples + 2 * gap_allowance + 100;
		// low across four rising edges, valid checked low throughout
		repeat (RESET_CYCLES) drive_cycle(1'b0, 1'b0);
		// sample output sits at zero while held in reset
		check_sample(cur_test, sample_t'(0), sample);
		arst_n = 1'b1;
		for (int t = 0; t < test_name.size(); t++) begin
			run_test(t);
		end
		for (int e = 0; e < expect_name.size(); e++) begin
			if (!expect_used[e]) begin
				abort_run($sformatf("trace expect for %s index %0d was never reached",
					expect_name[e], expect_index[e]));
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* tone_generator.f */
hdl/sine_pkg.sv
hdl/phase_accumulator.sv
hdl/quarter_sine_rom.sv
hdl/sine_lookup.sv
hdl/amplitude_scaler.sv
hdl/tone_generator.sv
verification/tone_generator_tb.sv

/* verification/tone_trace.txt */
# test   <name> <phase_step> <gain> <clear_at sample, -1 none> <sample count> <gap mode>
# expect <name> <sample index> <expected output sample>
test reset_sweep 1 256 -1 632 0
expect reset_sweep 0 20
expect reset_sweep 79 2910
expect reset_sweep 157 4095
expect reset_sweep 158 4095
expect reset_sweep 316 -20
expect reset_sweep 474 -4095
expect reset_sweep 631 -20
test wrap_step5 5 256 0 400 0
expect wrap_step5 158 4095
expect wrap_step5 316 -20
expect wrap_step5 395 2910
test wrap_step157 157 256 0 480 0
expect wrap_step157 1 4095
expect wrap_step157 317 -4095
expect wrap_step157 395 2910
expect wrap_step157 475 -20
test wrap_step631 631 256 0 320 0
expect wrap_step631 1 -20
expect wrap_step631 159 -4095
test gain_0 1 0 0 632 0
expect gain_0 157 0
test gain_1 1 1 0 632 0
expect gain_1 316 -1
expect gain_1 473 -16
test gain_128 1 128 0 632 0
expect gain_128 157 2047
expect gain_128 473 -2048
test gain_256 2 256 0 316 0
expect gain_256 79 4095
test clear_mid 3 256 100 300 0
expect clear_mid 100 20
expect clear_mid 258 -4095
test gap_latency 7 256 50 400 1
expect gap_latency 208 -4095
expect gap_latency 366 -20
test gap_half 1 128 0 200 1
expect gap_half 157 2047
